/* common/fetch_pkg.sv */
package fetch_pkg;

	// ******************************************************************
	// Address map of the fetch stage.
	// ******************************************************************

	typedef logic [31:0] addr_t;                          // Byte address.
	typedef logic [31:0] inst_t;                          // One RV32 instruction word.

	localparam addr_t reset_pc     = 32'h3000_0000;      // First fetch after reset, uncached.
	localparam addr_t cached_base  = 32'hA000_0000;      // First byte of the cacheable region.
	localparam addr_t cached_limit = 32'hA200_0000;      // First byte past the cacheable region.

	// ******************************************************************
	// Geometry of the direct-mapped instruction cache.
	// ******************************************************************

	localparam int line_bytes     = 32;                   // Bytes per cache line.
	localparam int words_per_line = 8;                    // Instruction words per line.
	localparam int line_count     = 16;                   // Lines in the cache.

	localparam int index_bits    = $clog2(line_count);     // 4 bits of line index.
	localparam int offset_bits   = $clog2(line_bytes);     // 5 bits of byte offset in a line.
	localparam int word_sel_bits = $clog2(words_per_line); // 3 bits select the word in a line.
	localparam int tag_bits      = 32 - index_bits - offset_bits; // What is left is the tag.

	typedef logic [tag_bits-1:0]   tag_t;                 // Upper address bits kept per line.
	typedef logic [index_bits-1:0] index_t;               // Selects one of the lines.

endpackage

/* common/bus_pkg.sv */
package bus_pkg;

	// ******************************************************************
	// Read address channel encodings.
	// ******************************************************************

	typedef logic [1:0] burst_t;                          // Burst type on arburst.
	typedef logic [3:0] len_t;                            // Beats minus one on arlen.

	localparam burst_t burst_fixed = 2'd0;                // Used for single-beat reads.
	localparam burst_t burst_incr  = 2'd1;                // Address steps by 4 per beat.

	localparam len_t refill_len = 4'd7;                   // Eight beats fill one cache line.
	localparam len_t single_len = 4'd0;                   // One beat for an uncached fetch.

	// ******************************************************************
	// Read data channel response codes.
	// ******************************************************************

	typedef logic [1:0] resp_t;                           // Response type on rresp.

	localparam resp_t resp_okay   = 2'd0;                 // Normal access success.
	localparam resp_t resp_slverr = 2'd2;                 // Slave reported an error.
	localparam resp_t resp_decerr = 2'd3;                 // No slave at this address.

endpackage

/* fetch/fetch_ctrl.sv */
`timescale 1ns/1ns

module fetch_ctrl (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              redirect_valid,
	input  fetch_pkg::addr_t  redirect_addr,
	input  logic              hit_valid,
	input  fetch_pkg::tag_t   hit_tag,
	input  fetch_pkg::inst_t  hit_data,
	input  logic              slot_ready,
	input  logic              mem_arready,
	input  logic              mem_rvalid,
	input  logic              mem_rlast,
	input  fetch_pkg::inst_t  mem_rdata,
	input  bus_pkg::resp_t    mem_rresp,
	output fetch_pkg::index_t lookup_index,
	output logic [2:0]        lookup_word,
	output logic              fill_en,
	output logic              fill_done,
	output logic              fill_ok,
	output fetch_pkg::index_t fill_index,
	output logic [2:0]        fill_word,
	output fetch_pkg::tag_t   fill_tag,
	output fetch_pkg::inst_t  fill_data,
	output logic              out_valid,
	output logic              out_fault,
	output fetch_pkg::addr_t  out_pc,
	output fetch_pkg::inst_t  out_inst,
	output fetch_pkg::addr_t  mem_araddr,
	output logic              mem_arvalid,
	output logic              mem_rready,
	output bus_pkg::burst_t   mem_arburst,
	output bus_pkg::len_t     mem_arlen
);

	typedef enum logic [2:0] {
		st_idle, st_lookup, st_compare, st_request, st_refill, st_single, st_drain
	} state_t;

	state_t           state_q, state_d;
	fetch_pkg::addr_t pc_q, pc_d;
	fetch_pkg::addr_t req_addr_q;                        // Address of the request on the bus.
	logic             req_cached_q;                      // The request is a line refill.
	logic             req_kill_q;                        // Redirect seen while arvalid was held.
	logic [2:0]       beat_q;                            // Word of the line the next beat fills.
	logic             line_ok_q;                         // No beat of this burst has failed.
	logic             cap_have_q;                        // A fetched word waits for handoff.
	logic             cap_fault_q;
	fetch_pkg::inst_t cap_inst_q;
	logic             hit, beat, last_beat, capture;

	function automatic logic in_cached(input fetch_pkg::addr_t addr);
		return addr >= fetch_pkg::cached_base && addr < fetch_pkg::cached_limit;
	endfunction

	// ******************************************************************
	// Lookup and handoff.
	// ******************************************************************

	assign lookup_index = pc_q[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
	assign lookup_word  = pc_q[2 +: fetch_pkg::word_sel_bits];
	assign hit          = hit_valid && hit_tag == pc_q[31 -: fetch_pkg::tag_bits];

	// Hits go out in compare and bus words go out from idle once captured.
	assign out_valid = slot_ready && !redirect_valid &&
		((state_q == st_idle && cap_have_q) || (state_q == st_compare && hit));
	assign out_pc    = pc_q;
	assign out_inst  = (state_q == st_idle) ? cap_inst_q : hit_data;
	assign out_fault = (state_q == st_idle) && cap_fault_q; // Cache hits never carry a fault.

	assign pc_d = redirect_valid ? redirect_addr : out_valid ? pc_q + 32'd4 : pc_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle:
				if (!redirect_valid && (out_valid || !cap_have_q))
					state_d = in_cached(pc_d) ? st_lookup : st_request;
			st_lookup:
				if (redirect_valid)
					state_d = st_idle;
				else if (slot_ready)
					state_d = st_compare;              // No lookup while decode stalls.
			st_compare:
				if (redirect_valid)
					state_d = st_idle;
				else if (!hit)
					state_d = st_request;              // A miss refills the line.
				else if (out_valid)
					state_d = in_cached(pc_d) ? st_lookup : st_request;
				else
					state_d = st_lookup;
			st_request:
				if (mem_arready)
					state_d = (req_kill_q || redirect_valid) ? st_drain :
						req_cached_q ? st_refill : st_single;
			default:
				if (last_beat)
					state_d = st_idle;
				else if (redirect_valid)
					state_d = st_drain;                // The burst still runs to its end.
		endcase
	end

	// ******************************************************************
	// Read channel and refill.
	// ******************************************************************

	assign mem_arvalid = state_q == st_request;
	assign mem_araddr  = req_addr_q;
	assign mem_arburst = req_cached_q ? bus_pkg::burst_incr : bus_pkg::burst_fixed;
	assign mem_arlen   = req_cached_q ? bus_pkg::refill_len : bus_pkg::single_len;
	assign mem_rready  = 1'b1;                           // Beats are always taken.

	assign beat      = mem_rvalid && mem_rready;
	assign last_beat = beat && mem_rlast;
	// The waiting word comes straight from its beat and is not read back.
	assign capture   = beat && !redirect_valid && (state_q == st_single ||
		(state_q == st_refill && beat_q == pc_q[2 +: fetch_pkg::word_sel_bits]));

	assign fill_en    = beat && req_cached_q && (state_q == st_refill || state_q == st_drain);
	assign fill_done  = fill_en && mem_rlast;
	assign fill_ok    = line_ok_q && mem_rresp == bus_pkg::resp_okay;
	assign fill_index = req_addr_q[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
	assign fill_tag   = req_addr_q[31 -: fetch_pkg::tag_bits];
	assign fill_word  = beat_q;
	assign fill_data  = mem_rdata;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= st_idle;
			pc_q       <= fetch_pkg::reset_pc;
			req_kill_q <= 1'b0;
			beat_q     <= '0;
			line_ok_q  <= 1'b1;
			cap_have_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			pc_q       <= pc_d;
			req_kill_q <= state_q == st_request && !mem_arready && (req_kill_q || redirect_valid);
			if (state_q == st_request) begin
				beat_q    <= '0;                     // Bursts start at word 0 of the line.
				line_ok_q <= 1'b1;
			end else if (beat) begin
				beat_q <= beat_q + 3'd1;
				if (mem_rresp != bus_pkg::resp_okay)
					line_ok_q <= 1'b0;               // One bad beat spoils the line.
			end
			if (redirect_valid || out_valid)
				cap_have_q <= 1'b0;
			else if (capture)
				cap_have_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (state_q != st_request && state_d == st_request) begin
			req_cached_q <= in_cached(pc_d);
			req_addr_q   <= in_cached(pc_d) ?
				{pc_d[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}} : pc_d;
		end
		if (capture) begin
			cap_inst_q  <= mem_rdata;
			cap_fault_q <= mem_rresp != bus_pkg::resp_okay;
		end
	end

	ar_stable_a: assert property (@(posedge clock) disable iff (!arst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

	// A refill that runs to its last beat has handed over the word the pc asked for.
	refill_cap_a: assert property (@(posedge clock) disable iff (!arst_n)
		state_q == st_refill && last_beat && !redirect_valid |=> cap_have_q);

endmodule

/* fetch/icache_store.sv */
`timescale 1ns/1ns

module icache_store (
	input  logic              clock,
	input  logic              arst_n,
	input  fetch_pkg::index_t lookup_index,
	input  logic [2:0]        lookup_word,
	input  logic              fill_en,
	input  fetch_pkg::index_t fill_index,
	input  logic [2:0]        fill_word,
	input  fetch_pkg::inst_t  fill_data,
	input  fetch_pkg::tag_t   fill_tag,
	input  logic              fill_done,
	input  logic              fill_ok,
	output logic              hit_valid,
	output fetch_pkg::tag_t   hit_tag,
	output fetch_pkg::inst_t  hit_data
);

	localparam int word_count = fetch_pkg::line_count * fetch_pkg::words_per_line;

	fetch_pkg::tag_t                   tag_q [fetch_pkg::line_count];
	fetch_pkg::inst_t                  data_q [word_count];
	logic [fetch_pkg::line_count-1:0]  valid_q;
	logic                              fill_open_q;        // A refill has begun but not ended.
	fetch_pkg::index_t                 fill_open_index;    // Line that the open refill writes.

	// ******************************************************************
	// Valid bits and refill tracking.
	// ******************************************************************

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q     <= '0;                           // Cache starts empty.
			hit_valid   <= 1'b0;
			fill_open_q <= 1'b0;
		end else begin
			hit_valid <= valid_q[lookup_index];
			if (fill_done)
				valid_q[fill_index] <= fill_ok;          // A faulted line stays invalid.
			if (fill_done)
				fill_open_q <= 1'b0;
			else if (fill_en)
				fill_open_q <= 1'b1;
		end
	end

	// ******************************************************************
	// Tag and data arrays.
	// ******************************************************************

	always_ff @(posedge clock) begin
		hit_tag  <= tag_q[lookup_index];                 // Synchronous read, one cycle.
		hit_data <= data_q[{lookup_index, lookup_word}];
		if (fill_en) begin
			data_q[{fill_index, fill_word}] <= fill_data;
			fill_open_index                 <= fill_index;
		end
		if (fill_done)
			tag_q[fill_index] <= fill_tag;               // The tag is written with the last beat.
	end

	fill_index_a: assert property (@(posedge clock) disable iff (!arst_n)
		fill_en && fill_open_q |-> fill_index == fill_open_index);

endmodule

/* hdl/decode_buffer.sv */
`timescale 1ns/1ns

module decode_buffer (
	input  logic             clock,
	input  logic             arst_n,
	input  logic             flush,
	input  logic             in_valid,
	input  fetch_pkg::addr_t in_pc,
	input  fetch_pkg::inst_t in_inst,
	input  logic             in_fault,
	input  logic             fetch_ready,
	output logic             slot_ready,
	output logic             fetch_valid,
	output fetch_pkg::addr_t fetch_pc,
	output fetch_pkg::inst_t fetch_inst,
	output logic             fetch_fault
);

	// Free when empty or when decode takes the entry this cycle.
	assign slot_ready = !fetch_valid || fetch_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			fetch_valid <= 1'b0;
		else if (flush)
			fetch_valid <= 1'b0;                         // Redirect drops the old path.
		else if (slot_ready)
			fetch_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (in_valid && slot_ready) begin
			fetch_pc    <= in_pc;
			fetch_inst  <= in_inst;
			fetch_fault <= in_fault;
		end
	end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
	input  logic             clock,
	input  logic             arst_n,
	input  logic             redirect_valid,
	input  fetch_pkg::addr_t redirect_addr,
	output logic             fetch_valid,
	output fetch_pkg::addr_t fetch_pc,
	output fetch_pkg::inst_t fetch_inst,
	output logic             fetch_fault,
	input  logic             fetch_ready,
	output fetch_pkg::addr_t mem_araddr,
	output logic             mem_arvalid,
	input  logic             mem_arready,
	output bus_pkg::burst_t  mem_arburst,
	output bus_pkg::len_t    mem_arlen,
	input  fetch_pkg::inst_t mem_rdata,
	input  bus_pkg::resp_t   mem_rresp,
	input  logic             mem_rlast,
	input  logic             mem_rvalid,
	output logic             mem_rready
);

	fetch_pkg::index_t lookup_index, fill_index;
	logic [2:0]        lookup_word, fill_word;
	logic              hit_valid;
	fetch_pkg::tag_t   hit_tag, fill_tag;
	fetch_pkg::inst_t  hit_data, fill_data;
	logic              fill_en, fill_done, fill_ok;
	logic              slot_ready, out_valid, out_fault;
	fetch_pkg::addr_t  out_pc;
	fetch_pkg::inst_t  out_inst;

	fetch_ctrl i_fetch_ctrl (
		.clock, .arst_n, .redirect_valid, .redirect_addr,
		.hit_valid, .hit_tag, .hit_data, .slot_ready,
		.mem_arready, .mem_rvalid, .mem_rlast, .mem_rdata, .mem_rresp,
		.lookup_index, .lookup_word,
		.fill_en, .fill_done, .fill_ok, .fill_index, .fill_word, .fill_tag, .fill_data,
		.out_valid, .out_fault, .out_pc, .out_inst,
		.mem_araddr, .mem_arvalid, .mem_rready, .mem_arburst, .mem_arlen
	);

	icache_store i_icache_store (
		.clock, .arst_n, .lookup_index, .lookup_word,
		.fill_en, .fill_index, .fill_word, .fill_data, .fill_tag, .fill_done, .fill_ok,
		.hit_valid, .hit_tag, .hit_data
	);

	// The redirect pulse doubles as the buffer flush.
	decode_buffer i_decode_buffer (
		.clock, .arst_n, .flush(redirect_valid),
		.in_valid(out_valid), .in_pc(out_pc), .in_inst(out_inst), .in_fault(out_fault),
		.fetch_ready, .slot_ready,
		.fetch_valid, .fetch_pc, .fetch_inst, .fetch_fault
	);

endmodule

/* sim/mem_model.sv */
`timescale 1ns/1ns

module mem_model (
	input  logic             clock,
	input  logic             arst_n,
	input  fetch_pkg::addr_t araddr,
	input  logic             arvalid,
	output logic             arready,
	input  bus_pkg::burst_t  arburst,
	input  bus_pkg::len_t    arlen,
	output fetch_pkg::inst_t rdata,
	output bus_pkg::resp_t   rresp,
	output logic             rlast,
	output logic             rvalid,
	input  logic             rready,
	output logic             idle
);

	localparam int ar_stall = 30;                        // Percent of cycles arready stays low.
	localparam int r_stall  = 30;                        // Percent of cycles with no beat.

	logic             busy;                              // A read is being answered.
	fetch_pkg::addr_t base;                              // Address taken on the AR handshake.
	bus_pkg::burst_t  burst;
	bus_pkg::len_t    len;
	bus_pkg::len_t    beat;                              // Beats already sent.
	fetch_pkg::addr_t word_addr;

	// Boot memory at the reset pc and 64 KB at the start of the cacheable region.
	function automatic logic mapped(input fetch_pkg::addr_t a);
		return (a >= 32'h3000_0000 && a < 32'h3001_0000) ||
			(a >= 32'hA000_0000 && a < 32'hA001_0000);
	endfunction

	assign word_addr = (burst == bus_pkg::burst_incr) ? base + {beat, 2'b00} : base;
	assign idle      = !busy;

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
		rresp   = bus_pkg::resp_okay;
	end

	// ******************************************************************
	// Handshakes are taken on the rising edge.
	// ******************************************************************

	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			beat <= '0;
		end else if (arvalid && arready) begin
			busy  <= 1'b1;                               // One outstanding read at a time.
			base  <= araddr;
			burst <= arburst;
			len   <= arlen;
			beat  <= '0;
		end else if (rvalid && rready) begin
			beat <= beat + 4'd1;
			if (rlast)
				busy <= 1'b0;
		end
	end

	// Outputs change on the falling edge, with random stalls on both channels.
	always @(negedge clock) begin
		if (!arst_n) begin
			arready = 1'b0;
			rvalid  = 1'b0;
		end else begin
			arready = !busy && ($urandom_range(99) >= ar_stall);
			rvalid  = busy && ($urandom_range(99) >= r_stall);
			rdata   = word_addr ^ 32'h5A5A_5A5A;         // Every word encodes its address.
			rresp   = mapped(word_addr) ? bus_pkg::resp_okay : bus_pkg::resp_decerr;
			rlast   = beat == len;
		end
	end

endmodule

/* sim/fetch_tb.sv */
`timescale 1ns/1ns

module fetch_tb;

	logic             clock;
	logic             arst_n;
	logic             redirect_valid;
	fetch_pkg::addr_t redirect_addr;
	logic             fetch_valid, fetch_fault, fetch_ready;
	fetch_pkg::addr_t fetch_pc, mem_araddr;
	fetch_pkg::inst_t fetch_inst, mem_rdata;
	logic             mem_arvalid, mem_arready, mem_rlast, mem_rvalid, mem_rready, mem_idle;
	bus_pkg::burst_t  mem_arburst;
	bus_pkg::len_t    mem_arlen;
	bus_pkg::resp_t   mem_rresp;

	logic [31:0]      patterns [0:255];                 // Five words per test step.
	int               req_count;                         // AR handshakes in the current step.
	int               cycle_count;
	int               cycle_limit;
	fetch_pkg::addr_t expected_pc;
	fetch_pkg::addr_t want_addr;                         // Address the next request should carry.

	fetch_top i_fetch_top (
		.clock, .arst_n, .redirect_valid, .redirect_addr,
		.fetch_valid, .fetch_pc, .fetch_inst, .fetch_fault, .fetch_ready,
		.mem_araddr, .mem_arvalid, .mem_arready, .mem_arburst, .mem_arlen,
		.mem_rdata, .mem_rresp, .mem_rlast, .mem_rvalid, .mem_rready
	);

	mem_model i_mem_model (
		.clock, .arst_n, .araddr(mem_araddr), .arvalid(mem_arvalid), .arready(mem_arready),
		.arburst(mem_arburst), .arlen(mem_arlen), .rdata(mem_rdata), .rresp(mem_rresp),
		.rlast(mem_rlast), .rvalid(mem_rvalid), .rready(mem_rready), .idle(mem_idle)
	);

	always #10 clock = ~clock;

	// ******************************************************************
	// Reference rules and compare tasks.
	// ******************************************************************

	function automatic logic cacheable(input fetch_pkg::addr_t a);
		return a >= 32'hA000_0000 && a < 32'hA200_0000;
	endfunction

	function automatic logic backed(input fetch_pkg::addr_t a);
		return (a >= 32'h3000_0000 && a < 32'h3001_0000) ||
			(a >= 32'hA000_0000 && a < 32'hA001_0000);
	endfunction

	// A cacheable fetch asks for its whole 32-byte line, any other fetch for its own word.
	function automatic fetch_pkg::addr_t request_addr(input fetch_pkg::addr_t pc);
		return cacheable(pc) ? pc & 32'hFFFF_FFE0 : pc;
	endfunction

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_pc(input string name, input fetch_pkg::addr_t got,
		input fetch_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERROR: %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
		if (got !== exp) begin
			$display("ERROR: fetch_inst got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_fault(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR: fetch_fault got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_burst(input bus_pkg::burst_t got, input bus_pkg::burst_t exp);
		if (got !== exp) begin
			$display("ERROR: mem_arburst got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input bus_pkg::len_t got, input bus_pkg::len_t exp);
		if (got !== exp) begin
			$display("ERROR: mem_arlen got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_requests(input int got, input int exp);
		if (got != exp) begin
			$display("ERROR: bus request count got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	// ******************************************************************
	// Bus request monitor and cycle limit.
	// ******************************************************************

	// The fetch stage asks for the word decode waits for or for the one after it.
	always @(posedge clock) begin
		if (arst_n && mem_arvalid && mem_arready) begin
			req_count = req_count + 1;
			want_addr = request_addr(expected_pc);
			if (mem_araddr !== want_addr)
				want_addr = request_addr(expected_pc + 32'd4);
			check_pc("mem_araddr", mem_araddr, want_addr);
			if (cacheable(want_addr)) begin                  // Line refill.
				check_burst(mem_arburst, bus_pkg::burst_incr);
				check_len(mem_arlen, bus_pkg::refill_len);
			end else begin
				check_burst(mem_arburst, bus_pkg::burst_fixed);
				check_len(mem_arlen, bus_pkg::single_len);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("The run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	// ******************************************************************
	// Stimulus tasks.
	// ******************************************************************

	task automatic issue_redirect(input fetch_pkg::addr_t target);
		@(negedge clock);
		redirect_valid = 1'b1;
		redirect_addr  = target;
		@(negedge clock);
		redirect_valid = 1'b0;
	endtask

	task automatic wait_for_request();
		int start;
		start = req_count;
		while (req_count == start)
			@(negedge clock);
	endtask

	// Transfers are judged on the falling edge, where valid, ready and data are stable.
	task automatic accept_instructions(input int count, input int stall);
		int accepted;
		accepted = 0;
		while (accepted < count) begin
			@(negedge clock);
			fetch_ready = $urandom_range(99) >= stall;
			if (fetch_ready && fetch_valid) begin
				check_pc("fetch_pc", fetch_pc, expected_pc);
				check_inst(fetch_inst, expected_pc ^ 32'h5A5A_5A5A);
				check_fault(fetch_fault, !backed(expected_pc));
				expected_pc = expected_pc + 32'd4;
				accepted    = accepted + 1;
			end
		end
		@(negedge clock);
		fetch_ready = 1'b0;
	endtask

	// With decode stalled the fetch stage fills its two slots and goes quiet.
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 8) begin
			@(negedge clock);
			if (fetch_valid && !mem_arvalid && mem_idle)
				quiet = quiet + 1;
			else
				quiet = 0;
		end
	endtask

	initial begin
		int step;
		int total;
		clock          = 1'b0;
		arst_n         = 1'b0;
		redirect_valid = 1'b0;
		redirect_addr  = '0;
		fetch_ready    = 1'b0;
		req_count      = 0;
		cycle_count    = 0;
		void'($urandom(32'h4c396233));
		$readmemh("sim/fetch_patterns.txt", patterns);
		total = 0;
		for (step = 0; patterns[step * 5] != 32'hF; step++)
			total = total + patterns[step * 5 + 2];
		cycle_limit = total * 60;                        // Sixty cycles per instruction.
		repeat (4) @(posedge clock);
		@(negedge clock);
		arst_n      = 1'b1;
		expected_pc = fetch_pkg::reset_pc;
		for (step = 0; patterns[step * 5] != 32'hF; step++) begin
			req_count = 0;
			if (patterns[step * 5] == 32'h1) begin
				issue_redirect(patterns[step * 5 + 1]);
			end else if (patterns[step * 5] == 32'h2) begin
				issue_redirect(patterns[step * 5 + 1] + 32'h100); // Decoy line to refill.
				expected_pc = patterns[step * 5 + 1] + 32'h100;
				wait_for_request();
				issue_redirect(patterns[step * 5 + 1]);  // Lands while the burst runs.
			end
			if (patterns[step * 5] != 32'h0)
				expected_pc = patterns[step * 5 + 1];
			accept_instructions(patterns[step * 5 + 2], patterns[step * 5 + 3]);
			wait_quiet();
			check_requests(req_count, patterns[step * 5 + 4]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* sim/fetch_patterns.txt */
// Columns: mode (0 go on, 1 redirect, 2 redirect during a refill, F end), address,
// instructions to accept, stall percent, expected bus requests. All values are hex.
// Uncached fetch from reset.
0 00000000 4 0 6
// Miss on line 0, then the next line is refilled ahead.
1 A0000000 8 0 2
// Same line again, all hits.
1 A0000000 8 0 0
// Redirect while the decoy line at A0000300 is refilling.
2 A0000200 4 0 2
// Uncached with decode stalls.
1 30000100 C 32 E
// Two fresh lines with decode stalls, one line ahead.
1 A0000040 10 28 3
// Unmapped uncached address.
1 50000000 2 0 4
// Unmapped cacheable line answers decerr.
1 A1000000 1 0 2
// The faulted line stays invalid and is fetched again.
1 A1000000 1 0 2
// Back to the boot region.
1 30000000 3 19 5
F 00000000 0 0 0

/* sources.f */
common/fetch_pkg.sv
common/bus_pkg.sv
fetch/fetch_ctrl.sv
fetch/icache_store.sv
hdl/decode_buffer.sv
hdl/fetch_top.sv
sim/mem_model.sv
sim/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - common/fetch_pkg.sv
  - common/bus_pkg.sv
  - fetch/fetch_ctrl.sv
  - fetch/icache_store.sv
  - hdl/decode_buffer.sv
  - hdl/fetch_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/fetch_tb.sv
